/* compile.f */
+incdir+hdl
hdl/pipeTypesPkg.sv
hdl/hazardPkg.sv
hdl/hazardUnit.sv
hdl/divSequencer.sv
hdl/pipeTrack.sv
hdl/pipeCtrlTop.sv
verification/pipeCtrl_properties.sv
verification/pipeCtrlTb.sv

/* Makefile */
# Verilator build, run and lint for the pipeline control testbench
# Any variable can be overridden on the command line, e.g. make TOP=pipeCtrlTb

VERILATOR   ?= verilator
TOP         ?= pipeCtrlTb
FILELIST    ?= compile.f
OBJ_DIR     ?= obj_dir
TIMESCALE   ?= 1ns/10ps
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing --assert
SIM_FLAGS   ?= +verilator+error+limit+1000
PASS_TEXT   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# The run passes only when the simulation output holds the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/pipeCtrlTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pipe_settings.svh"

module pipeCtrlTb;

  //////////////////////////////////////////////////
  // Run length
  //////////////////////////////////////////////////

  localparam int ResetCycles = 5;
  localparam int PhaseCycles = 450;
  localparam int DrainCycles = 40;
  // Longest wait for a single token to come out of Writeback
  localparam int LatencyLimit = 40;
  localparam int StimulusCycles = ResetCycles + 2 * LatencyLimit + 4 * PhaseCycles + DrainCycles;
  localparam int TimeoutCycles = 2 * StimulusCycles;
  // One edge to capture into Fetch plus four stage moves to reach Writeback
  localparam int PlainLatency = pipeTypesPkg::NumStages;

  typedef enum {PhaseQuiet, PhaseDivide, PhaseFlush, PhaseWfi} phaseT;

  logic                     clk;
  logic                     rstN;
  pipeTypesPkg::stageTokenT fetch;
  hazardPkg::hazardCauseT   causes;
  logic                     intPending;
  hazardPkg::stallFlushT    ctrl;
  pipeTypesPkg::stageTokenT retire;
  logic                     retireStrobe;

  int                     seed = 32'he7c6_ecb2;
  int                     errorCount = 0;
  int                     retireCount = 0;
  int                     cycleCount = 0;
  int                     plainLatency;
  int                     divLatency;
  logic                   fetchTaken = 1'b1;
  // Set while no event can kill an instruction, so tags must retire one by one
  logic                   contiguous = 1'b0;
  logic                   haveLast = 1'b0;
  pipeTypesPkg::instrTagT nextTag = '0;
  pipeTypesPkg::instrTagT lastTag = '0;
  // Divide and WFI flags of each issued tag
  logic [1:0]             issuedFlags [2**`PIPE_TAG_WIDTH];

  pipeCtrlTop i_dut (
    .clk          (clk),
    .rstN         (rstN),
    .fetch        (fetch),
    .causes       (causes),
    .intPending   (intPending),
    .ctrl         (ctrl),
    .retire       (retire),
    .retireStrobe (retireStrobe)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic percentHit(input int unsigned percent);
    int unsigned draw;
    draw = $unsigned($random(seed)) % 100;
    return draw < percent;
  endfunction

  function automatic hazardPkg::hazardCauseT randomCauses(input phaseT phase);
    hazardPkg::hazardCauseT c;
    c = '0;
    case (phase)
      // Mispredictions while divides are busy exercise the Execute protection
      PhaseDivide: begin
        c.bpWrongE = percentHit(25);
        c.structuralStallD = percentHit(10);
        c.lsuStallM = percentHit(5);
        c.trapM = percentHit(3);
      end
      PhaseFlush: begin
        c.trapM = percentHit(10);
        c.retM = percentHit(8);
        c.csrWriteFenceM = percentHit(8);
        c.bpWrongE = percentHit(20);
        c.fpuStallD = percentHit(10);
        c.ifuStallF = percentHit(8);
        c.lsuStallM = percentHit(8);
        c.externalStall = percentHit(3);
        c.debugMode = percentHit(3);
      end
      // Traps against parked WFIs reach the interrupted-WFI case
      PhaseWfi: begin
        c.trapM = percentHit(12);
        c.structuralStallD = percentHit(5);
        c.ifuStallF = percentHit(5);
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  task automatic reportError(input string msg);
    errorCount++;
    $display("ERR %0d ns: %s", $time, msg);
  endtask

  // Sampled at the falling edge, when every control level has settled
  task automatic checkRetire();
    pipeTypesPkg::instrTagT tagStep;
    tagStep = retire.tag - lastTag;
    if (retireStrobe && ctrl.stallW) begin
      reportError("retire strobe high while Writeback is stalled");
    end
    if (retireStrobe) begin
      // A step of zero or of half the tag range or more means out of order
      if (haveLast && (tagStep == '0 || tagStep[`PIPE_TAG_WIDTH-1])) begin
        reportError($sformatf("tag %0d retired after tag %0d", retire.tag, lastTag));
      end else if (haveLast && contiguous && tagStep != pipeTypesPkg::instrTagT'(1)) begin
        reportError($sformatf("tag %0d skipped ahead of tag %0d", retire.tag, lastTag));
      end
      if ({retire.isDiv, retire.isWfi} != issuedFlags[retire.tag]) begin
        reportError($sformatf("tag %0d retired with wrong kind flags", retire.tag));
      end
      lastTag = retire.tag;
      haveLast = 1'b1;
      retireCount++;
    end
  endtask

  // One clock cycle; the source holds its token while Fetch is stalled
  task automatic runCycle(input hazardPkg::hazardCauseT c, input logic intP,
                          input logic wantFetch, input logic makeDiv, input logic makeWfi);
    @(posedge clk);
    #1;
    causes = c;
    intPending = intP;
    if (fetchTaken) begin
      if (wantFetch) begin
        fetch.valid = 1'b1;
        fetch.tag = nextTag;
        fetch.isDiv = makeDiv;
        fetch.isWfi = makeWfi;
        issuedFlags[nextTag] = {makeDiv, makeWfi};
        nextTag = nextTag + pipeTypesPkg::instrTagT'(1);
      end else begin
        fetch = '0;
      end
    end
    @(negedge clk);
    fetchTaken = !ctrl.stallF;
    checkRetire();
  endtask

  task automatic measureLatency(input logic asDiv, output int latency);
    pipeTypesPkg::instrTagT target;
    logic seen;
    target = nextTag;
    seen = 1'b0;
    latency = 0;
    runCycle('0, 1'b0, 1'b1, asDiv, 1'b0);
    while (!seen && latency < LatencyLimit) begin
      runCycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
      latency++;
      seen = retireStrobe && retire.tag == target;
    end
    if (!seen) begin
      errorCount++;
      $display("Single token with tag %0d never retired within %0d cycles", target, LatencyLimit);
    end
  endtask

  task automatic runPhase(input phaseT phase, input int unsigned divPercent,
                          input int unsigned wfiPercent, input int unsigned intPercent);
    logic wantDiv;
    logic wantWfi;
    contiguous = (phase == PhaseQuiet);
    for (int i = 0; i < PhaseCycles; i++) begin
      wantDiv = percentHit(divPercent);
      wantWfi = !wantDiv && percentHit(wfiPercent);
      runCycle(randomCauses(phase), percentHit(intPercent), percentHit(80), wantDiv, wantWfi);
    end
    contiguous = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    fetch = '0;
    causes = '0;
    intPending = 1'b0;
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Divide occupancy on an otherwise empty, quiet pipeline
    measureLatency(1'b0, plainLatency);
    measureLatency(1'b1, divLatency);
    if (plainLatency != PlainLatency) begin
      reportError($sformatf("plain token took %0d cycles, expected %0d",
                            plainLatency, PlainLatency));
    end
    if (divLatency != plainLatency + `PIPE_DIV_CYCLES) begin
      reportError($sformatf("divide took %0d cycles, expected %0d",
                            divLatency, plainLatency + `PIPE_DIV_CYCLES));
    end

    // A pending interrupt keeps WFIs from parking during the quiet phase
    runPhase(PhaseQuiet, 5, 5, 100);
    runPhase(PhaseDivide, 40, 5, 50);
    runPhase(PhaseFlush, 10, 10, 30);
    runPhase(PhaseWfi, 5, 30, 20);
    repeat (DrainCycles) runCycle('0, 1'b1, 1'b0, 1'b0, 1'b0);

    $display("Run over after %0d cycles: %0d retired, %0d retire errors, %0d assertion failures",
             cycleCount, retireCount, errorCount, i_dut.i_props.failCount);
    if (errorCount == 0 && i_dut.i_props.failCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/pipeCtrl_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// Rule checks on the stall and flush control leaving the hazard unit
// Bound into the top level, where the clock and every hazard unit port are visible
module pipeCtrlProperties (
  input logic                   clk,
  input logic                   rstN,
  input hazardPkg::hazardCauseT causes,
  input logic                   divBusyE,
  input logic                   wfiM,
  input logic                   intPending,
  input hazardPkg::stallFlushT  ctrl
);

  // Running count of rule violations
  int failCount = 0;

  logic chainOk;
  logic bubbleOk;
  logic systemFlush;

  // A stall anywhere must hold every stage in front of it
  assign chainOk = (~ctrl.stallW | ctrl.stallM) & (~ctrl.stallM | ctrl.stallE) &
                   (~ctrl.stallE | ctrl.stallD) & (~ctrl.stallD | ctrl.stallF);

  // The first stage that moves behind a held stage takes a bubble
  assign bubbleOk = (~(ctrl.stallF & ~ctrl.stallD) | ctrl.flushD) &
                    (~(ctrl.stallD & ~ctrl.stallE) | ctrl.flushE) &
                    (~(ctrl.stallE & ~ctrl.stallM) | ctrl.flushM) &
                    (~(ctrl.stallM & ~ctrl.stallW) | ctrl.flushW);

  // Events in Memory that discard every younger instruction
  assign systemFlush = causes.trapM | causes.retM | causes.csrWriteFenceM;

  stallChain: assert property (@(posedge clk) disable iff (!rstN) chainOk)
    else begin
      failCount++;
      $error("Stall chain broken, an earlier stage moves while a later one is held");
    end

  bubbleInsert: assert property (@(posedge clk) disable iff (!rstN) bubbleOk)
    else begin
      failCount++;
      $error("Missing bubble behind a stalled stage");
    end

  // Writeback survives only when the trap is the interrupt that wakes a WFI
  trapFlush: assert property (@(posedge clk) disable iff (!rstN)
      causes.trapM |-> (ctrl.flushD && ctrl.flushE && ctrl.flushM &&
                        (ctrl.flushW == !(wfiM && intPending))))
    else begin
      failCount++;
      $error("Trap did not flush the expected stages");
    end

  divideKeep: assert property (@(posedge clk) disable iff (!rstN)
      (causes.bpWrongE && divBusyE && !systemFlush) |-> (ctrl.flushD && !ctrl.flushE))
    else begin
      failCount++;
      $error("Misprediction flushed a busy divide out of Execute");
    end

endmodule

bind pipeCtrlTop pipeCtrlProperties i_props (
  .clk        (clk),
  .rstN       (rstN),
  .causes     (causes),
  .divBusyE   (divBusyE),
  .wfiM       (wfiM),
  .intPending (intPending),
  .ctrl       (ctrl)
);

`default_nettype wire

/* hdl/pipeCtrlTop.sv */
`timescale 1ns/10ps
`default_nettype none

// Pipeline control top level
// Token tracker and divide model feed the hazard unit, whose control loops back to both
module pipeCtrlTop (
  input  logic                     clk,
  input  logic                     rstN,
  input  pipeTypesPkg::stageTokenT fetch,
  input  hazardPkg::hazardCauseT   causes,
  input  logic                     intPending,
  output hazardPkg::stallFlushT    ctrl,
  output pipeTypesPkg::stageTokenT retire,
  output logic                     retireStrobe
);

  pipeTypesPkg::stageTokenT tokenE;
  logic                     wfiM;
  logic                     divBusyE;

  // Stage registers for the tokens in flight
  pipeTrack i_pipeTrack (
    .clk          (clk),
    .rstN         (rstN),
    .fetch        (fetch),
    .ctrl         (ctrl),
    .tokenE       (tokenE),
    .wfiM         (wfiM),
    .retire       (retire),
    .retireStrobe (retireStrobe)
  );

  // Holds Execute while a divide is running
  divSequencer i_divSequencer (
    .clk      (clk),
    .rstN     (rstN),
    .tokenE   (tokenE),
    .ctrl     (ctrl),
    .divBusyE (divBusyE)
  );

  // Zero-cycle path from causes to the per-stage control
  hazardUnit i_hazardUnit (
    .causes     (causes),
    .divBusyE   (divBusyE),
    .wfiM       (wfiM),
    .intPending (intPending),
    .ctrl       (ctrl)
  );

endmodule

`default_nettype wire

/* hdl/pipeTrack.sv */
`timescale 1ns/10ps
`default_nettype none

// Carries instruction tokens through the five stage registers
// No datapath here, only the identity of what sits in each stage
module pipeTrack (
  input  logic                     clk,
  input  logic                     rstN,
  input  pipeTypesPkg::stageTokenT fetch,
  input  hazardPkg::stallFlushT    ctrl,
  output pipeTypesPkg::stageTokenT tokenE,
  output logic                     wfiM,
  output pipeTypesPkg::stageTokenT retire,
  output logic                     retireStrobe
);

  localparam int NumStages = pipeTypesPkg::NumStages;

  // Stage positions in the register array, oldest last
  localparam int StageF = 0;
  localparam int StageD = 1;
  localparam int StageE = 2;
  localparam int StageM = 3;
  localparam int StageW = 4;

  pipeTypesPkg::stageTokenT stageQ [NumStages];

  logic [NumStages-1:0] stallVec;
  // Fetch never flushes, so the vector starts at Decode
  logic [StageW:StageD] flushVec;

  //////////////////////////////////////////////////
  // Control fan-out
  //////////////////////////////////////////////////

  // Index the struct fields by stage so the register update is one loop
  assign stallVec[StageF] = ctrl.stallF;
  assign stallVec[StageD] = ctrl.stallD;
  assign stallVec[StageE] = ctrl.stallE;
  assign stallVec[StageM] = ctrl.stallM;
  assign stallVec[StageW] = ctrl.stallW;

  assign flushVec[StageD] = ctrl.flushD;
  assign flushVec[StageE] = ctrl.flushE;
  assign flushVec[StageM] = ctrl.flushM;
  assign flushVec[StageW] = ctrl.flushW;

  //////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int s = 0; s < NumStages; s++) begin
        stageQ[s] <= pipeTypesPkg::BubbleToken;
      end
    end else begin
      // The fetch source holds its token steady while F is stalled
      if (!stallVec[StageF]) begin
        stageQ[StageF] <= fetch;
      end
      // Flush beats stall, and a moving stage copies the one ahead of it
      for (int s = StageD; s < NumStages; s++) begin
        if (flushVec[s]) begin
          stageQ[s] <= pipeTypesPkg::BubbleToken;
        end else if (!stallVec[s]) begin
          stageQ[s] <= stageQ[s-1];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage taps
  //////////////////////////////////////////////////

  // The divide sequencer watches Execute
  assign tokenE = stageQ[StageE];

  // The hazard unit only needs to know that a real WFI sits in Memory
  assign wfiM = stageQ[StageM].valid & stageQ[StageM].isWfi;

  assign retire = stageQ[StageW];
  // W commits once per instruction, on the cycle it is allowed to leave
  assign retireStrobe = stageQ[StageW].valid & ~ctrl.stallW;

endmodule

`default_nettype wire

/* hdl/divSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pipe_settings.svh"

// Models the occupancy of a multi-cycle integer divide in Execute
// Busy rises as soon as a divide token shows up in E and lasts PIPE_DIV_CYCLES cycles
module divSequencer (
  input  logic                     clk,
  input  logic                     rstN,
  input  pipeTypesPkg::stageTokenT tokenE,
  input  hazardPkg::stallFlushT    ctrl,
  output logic                     divBusyE
);

  localparam int CountWidth = $clog2(`PIPE_DIV_CYCLES + 1);
  // The first busy cycle is covered by newDiv, the counter handles the rest
  localparam logic [CountWidth-1:0] LoadValue = CountWidth'(`PIPE_DIV_CYCLES - 1);

  logic [CountWidth-1:0] count;
  logic                  done;
  logic                  newDiv;
  logic                  advanceE;

  // A divide in E that has not started yet
  assign newDiv = tokenE.valid & tokenE.isDiv & ~done;

  // E loads a new token on this edge, either the next one or a bubble
  assign advanceE = ctrl.flushE | ~ctrl.stallE;

  assign divBusyE = newDiv | (count != '0);

  // Done stays set after the count runs out so that a finished divide
  // held by a later stall does not start over
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
      done  <= 1'b0;
    end else if (advanceE) begin
      // Leaving E, whether retired forward or killed by a flush
      count <= '0;
      done  <= 1'b0;
    end else if (newDiv) begin
      count <= LoadValue;
      done  <= 1'b1;
    end else if (count != '0) begin
      count <= count - CountWidth'(1);
    end
  end

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

// Turns the raw stall and flush events into one stall and one flush per stage
// Purely combinational, so the stage registers see the result in the same cycle
module hazardUnit (
  input  hazardPkg::hazardCauseT causes,
  input  logic                   divBusyE,
  input  logic                   wfiM,
  input  logic                   intPending,
  output hazardPkg::stallFlushT  ctrl
);

  logic wfiStallM, wfiInterruptedM;
  logic flushDCause, flushECause, flushMCause, flushWCause;
  logic stallDCause, stallECause, stallMCause, stallWCause;
  logic latestUnstalledE, latestUnstalledM, latestUnstalledW;

  //////////////////////////////////////////////////
  // Wait-for-interrupt
  //////////////////////////////////////////////////

  // A WFI in Memory sleeps until something is pending
  assign wfiStallM = wfiM & ~intPending;
  // Once an interrupt arrives the WFI must still commit before the trap
  assign wfiInterruptedM = wfiM & intPending;

  //////////////////////////////////////////////////
  // Flush causes
  //////////////////////////////////////////////////

  // Traps, returns and CSR writes or fences discard everything younger than Memory
  // A mispredicted branch discards the two instructions fetched behind it
  assign flushDCause = causes.trapM | causes.retM | causes.csrWriteFenceM | causes.bpWrongE;
  // A divide sitting in Execute must survive a misprediction seen in the same slot
  assign flushECause = causes.trapM | causes.retM | causes.csrWriteFenceM |
                       (causes.bpWrongE & ~divBusyE);
  assign flushMCause = causes.trapM | causes.retM | causes.csrWriteFenceM;
  // An interrupted WFI retires from Writeback, every other trap kills it
  assign flushWCause = causes.trapM & ~wfiInterruptedM;

  //////////////////////////////////////////////////
  // Stall causes
  //////////////////////////////////////////////////

  // Each cause is masked by its own stage's flush so a flushed stage always moves
  assign stallDCause = (causes.structuralStallD | causes.fpuStallD) & ~flushDCause;
  assign stallECause = divBusyE & ~flushECause;
  assign stallMCause = wfiStallM & ~flushMCause;
  // Fetch stalls freeze the whole machine, but not when Decode is being flushed
  // FlushW is a subset of flushD, so the LSU term only needs the W flush mask
  assign stallWCause = (causes.ifuStallF & ~flushDCause) |
                       (causes.lsuStallM & ~flushWCause) |
                       causes.debugMode | causes.externalStall;

  // A stage stalls on its own cause or when the stage after it stalls
  assign ctrl.stallW = stallWCause;
  assign ctrl.stallM = stallMCause | ctrl.stallW;
  assign ctrl.stallE = stallECause | ctrl.stallM;
  assign ctrl.stallD = stallDCause | ctrl.stallE;
  // Fetch has no cause of its own and simply follows Decode
  assign ctrl.stallF = ctrl.stallD;

  //////////////////////////////////////////////////
  // Bubble insertion
  //////////////////////////////////////////////////

  // The first stage that moves behind a held one must not copy the held token
  // Fetch stalls exactly when Decode does, so Decode never moves behind a held Fetch
  assign latestUnstalledE = ~ctrl.stallE & ctrl.stallD;
  assign latestUnstalledM = ~ctrl.stallM & ctrl.stallE;
  assign latestUnstalledW = ~ctrl.stallW & ctrl.stallM;

  // Flush on a system event or when this stage is the first unstalled one
  assign ctrl.flushD = flushDCause;
  assign ctrl.flushE = latestUnstalledE | flushECause;
  assign ctrl.flushM = latestUnstalledM | flushMCause;
  assign ctrl.flushW = latestUnstalledW | flushWCause;

endmodule

`default_nettype wire

/* hdl/hazardPkg.sv */
`default_nettype none

package hazardPkg;

  //////////////////////////////////////////////////
  // Events that ask the pipeline to stall or flush
  //////////////////////////////////////////////////

  // Levels from the datapath, caches, CSR file and branch predictor
  // The suffix names the stage where each event is detected
  typedef struct packed {
    // Branch outcome in Execute disagrees with the prediction
    logic bpWrongE;
    // CSR write or fence in Memory forces a refetch of younger instructions
    logic csrWriteFenceM;
    // Trap return in Memory
    logic retM;
    // Exception or interrupt taken in Memory
    logic trapM;
    // Decode waits on a busy functional unit or a load-use dependency
    logic structuralStallD;
    logic fpuStallD;
    // Long cache or bus operations freeze the whole pipeline
    logic lsuStallM;
    logic ifuStallF;
    // Level from outside the core and the plain debug halt
    logic externalStall;
    logic debugMode;
  } hazardCauseT;

  //////////////////////////////////////////////////
  // Resolved per-stage control
  //////////////////////////////////////////////////

  // A stalled stage keeps its register, a flushed stage loads a bubble
  // Fetch has no flush because it never holds a speculative bubble of its own
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } stallFlushT;

endpackage

`default_nettype wire

/* hdl/pipeTypesPkg.sv */
`default_nettype none

`include "pipe_settings.svh"

package pipeTypesPkg;

  //////////////////////////////////////////////////
  // Instructions in flight
  //////////////////////////////////////////////////

  // Fetch, Decode, Execute, Memory and Writeback
  localparam int NumStages = 5;

  // Program-order number given to an instruction when it is fetched
  typedef logic [`PIPE_TAG_WIDTH-1:0] instrTagT;

  // One pipeline slot
  // A cleared valid bit marks a bubble and the other fields are then don't-care
  typedef struct packed {
    logic     valid;
    instrTagT tag;
    // Divide instructions hold Execute busy for several cycles
    logic     isDiv;
    // Wait-for-interrupt parks in Memory until an interrupt is pending
    logic     isWfi;
  } stageTokenT;

  // Value a stage register takes when it is flushed or reset
  localparam stageTokenT BubbleToken = '0;

endpackage

`default_nettype wire

/* hdl/pipe_settings.svh */
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Width of the program-order sequence tag carried by every token
// Tags wrap around, so order is only meaningful modulo this width
`define PIPE_TAG_WIDTH 8

// Extra cycles a divide stays in Execute after it arrives there
// The divide occupies Execute for this many cycles plus the one it advances on
`define PIPE_DIV_CYCLES 4

`endif
